/* include/hydra_cfg.svh */
`ifndef HYDRA_CFG_SVH
`define HYDRA_CFG_SVH

// switch size, one bank per port
`define HYDRA_PORTS 4
`define HYDRA_WORD 16

// bank layout, each packet sits in one contiguous slot
`define HYDRA_SLOTS 4
`define HYDRA_SLOT_WORDS 16

// egress queues
`define HYDRA_PRIORS 4
// deep enough for every slot in the switch
`define HYDRA_QDEPTH 16

`endif

/* hw/hydra_pkg.sv */
`include "hydra_cfg.svh"

package hydra_pkg;

    // header word layout is dest [1:0], prio [3:2], tag [15:4]
    typedef logic [`HYDRA_WORD-1:0] word_t;

    typedef logic [$clog2(`HYDRA_PORTS)-1:0] port_idx_t;
    typedef logic [$clog2(`HYDRA_SLOTS)-1:0] slot_idx_t;
    typedef logic [$clog2(`HYDRA_SLOT_WORDS)-1:0] offset_t;
    // length runs 1..SLOT_WORDS, one bit wider than an offset
    typedef logic [$clog2(`HYDRA_SLOT_WORDS):0] len_t;
    typedef logic [$clog2(`HYDRA_PRIORS)-1:0] prio_t;
    typedef logic [$clog2(`HYDRA_QDEPTH):0] qptr_t;

    typedef struct packed {
        port_idx_t bank;
        slot_idx_t slot;
        len_t      len;
        prio_t     prio;
    } desc_t;

    typedef enum logic {i_idle, i_recv} ingress_state_e;

    typedef enum logic [1:0] {e_idle, e_wait_grant, e_stream} egress_state_e;

endpackage

/* hw/ingress_port.sv */
module ingress_port #(
    parameter hydra_pkg::port_idx_t BANK_ID = '0
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 wr_sop,
    input  logic                 wr_vld,
    input  logic                 wr_eop,
    input  hydra_pkg::word_t     wr_data,
    input  logic                 slot_free,
    input  hydra_pkg::slot_idx_t alloc_slot,
    output logic                 pause,
    output logic                 alloc,
    output logic                 wr_en,
    output hydra_pkg::slot_idx_t wr_slot,
    output hydra_pkg::offset_t   wr_offset,
    output hydra_pkg::word_t     wr_word,
    output logic                 join_req,
    output hydra_pkg::desc_t     join_desc,
    output hydra_pkg::port_idx_t join_dest,
    input  logic                 join_grant
);

    hydra_pkg::ingress_state_e state;
    hydra_pkg::slot_idx_t      cur_slot;
    hydra_pkg::offset_t        count;
    hydra_pkg::port_idx_t      cur_dest;
    hydra_pkg::prio_t          cur_prio;

    logic                      start;
    hydra_pkg::slot_idx_t      pkt_slot;
    hydra_pkg::port_idx_t      pkt_dest;
    hydra_pkg::prio_t          pkt_prio;

    // a packet only opens from idle
    assign start = (state == hydra_pkg::i_idle) && wr_sop && wr_vld;
    assign alloc = start;

    // header word goes straight into offset 0 of the fresh slot
    always_comb begin
        if (state == hydra_pkg::i_idle) begin
            pkt_slot  = alloc_slot;
            pkt_dest  = wr_data[1:0];
            pkt_prio  = wr_data[3:2];
            wr_offset = '0;
        end else begin
            pkt_slot  = cur_slot;
            pkt_dest  = cur_dest;
            pkt_prio  = cur_prio;
            wr_offset = count;
        end
    end

    assign wr_en   = wr_vld && (start || state == hydra_pkg::i_recv);
    assign wr_slot = pkt_slot;
    assign wr_word = wr_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= hydra_pkg::i_idle;
            pause    <= 1'b0;
            join_req <= 1'b0;
        end else begin
            pause <= !slot_free;
            if (start && !wr_eop) begin
                state <= hydra_pkg::i_recv;
            end else if (state == hydra_pkg::i_recv && wr_vld && wr_eop) begin
                state <= hydra_pkg::i_idle;
            end
            // held until the arbiter takes it
            if (wr_en && wr_eop) begin
                join_req <= 1'b1;
            end else if (join_grant) begin
                join_req <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            cur_slot <= alloc_slot;
            cur_dest <= wr_data[1:0];
            cur_prio <= wr_data[3:2];
        end
        if (wr_en) begin
            count <= wr_offset + 1'b1;
        end
        if (wr_en && wr_eop) begin
            join_desc.bank <= BANK_ID;
            join_desc.slot <= pkt_slot;
            join_desc.len  <= hydra_pkg::len_t'(wr_offset) + 1'b1;
            join_desc.prio <= pkt_prio;
            join_dest      <= pkt_dest;
        end
    end

    // source has to see pause low before opening a packet
    assert property (@(posedge clk) disable iff (!rst_n) wr_sop && wr_vld |-> !pause)
        else $error("ingress_port %0d: wr_sop while pause high", BANK_ID);

endmodule

/* hw/packet_bank.sv */
`include "hydra_cfg.svh"

module packet_bank (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    alloc,
    input  logic                                    wr_en,
    input  hydra_pkg::slot_idx_t                    wr_slot,
    input  hydra_pkg::offset_t                      wr_offset,
    input  hydra_pkg::word_t                        wr_word,
    input  logic [`HYDRA_PORTS-1:0]                 rd_req,
    input  hydra_pkg::slot_idx_t [`HYDRA_PORTS-1:0] rd_slot,
    input  hydra_pkg::offset_t [`HYDRA_PORTS-1:0]   rd_offset,
    input  logic [`HYDRA_PORTS-1:0]                 rd_release,
    output logic                                    slot_free,
    output hydra_pkg::slot_idx_t                    alloc_slot,
    output logic [`HYDRA_PORTS-1:0]                 rd_grant,
    output hydra_pkg::word_t                        rd_word
);

    localparam int DEPTH = `HYDRA_SLOTS * `HYDRA_SLOT_WORDS;

    hydra_pkg::word_t        mem [DEPTH];
    logic [`HYDRA_SLOTS-1:0] free_map;
    logic                    own_vld;
    hydra_pkg::port_idx_t    owner;
    hydra_pkg::port_idx_t    req_idx;

    // lowest free slot
    always_comb begin
        alloc_slot = '0;
        for (int s = `HYDRA_SLOTS - 1; s >= 0; s--) begin
            if (free_map[s]) begin
                alloc_slot = hydra_pkg::slot_idx_t'(s);
            end
        end
    end

    assign slot_free = |free_map;

    // lowest requesting egress port
    always_comb begin
        req_idx = '0;
        for (int p = `HYDRA_PORTS - 1; p >= 0; p--) begin
            if (rd_req[p]) begin
                req_idx = hydra_pkg::port_idx_t'(p);
            end
        end
    end

    always_comb begin
        for (int p = 0; p < `HYDRA_PORTS; p++) begin
            rd_grant[p] = own_vld && (owner == hydra_pkg::port_idx_t'(p));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            free_map <= '1;
        end else begin
            if (alloc) begin
                free_map[alloc_slot] <= 1'b0;
            end
            // only the owner may hand a slot back
            if (own_vld && rd_release[owner]) begin
                free_map[rd_slot[owner]] <= 1'b1;
            end
        end
    end

    // owner keeps the read port until its request drops
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            own_vld <= 1'b0;
            owner   <= '0;
        end else if (own_vld) begin
            if (!rd_req[owner]) begin
                own_vld <= 1'b0;
            end
        end else if (|rd_req) begin
            own_vld <= 1'b1;
            owner   <= req_idx;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[{wr_slot, wr_offset}] <= wr_word;
        end
        rd_word <= mem[{rd_slot[owner], rd_offset[owner]}];
    end

    // a granted port keeps the read port while it still asks
    assert property (@(posedge clk) disable iff (!rst_n)
        |(rd_grant & rd_req) |=> rd_grant == $past(rd_grant))
        else $error("packet_bank: read grant moved while still requested");

    // the opening write lands in the slot being allocated that cycle
    assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> !free_map[wr_slot] || (alloc && wr_slot == alloc_slot))
        else $error("packet_bank: write into unallocated slot %0d", wr_slot);

endmodule

/* hw/join_arbiter.sv */
`include "hydra_cfg.svh"

module join_arbiter (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic [`HYDRA_PORTS-1:0]                 join_req,
    input  hydra_pkg::desc_t [`HYDRA_PORTS-1:0]     join_desc,
    input  hydra_pkg::port_idx_t [`HYDRA_PORTS-1:0] join_dest,
    output logic [`HYDRA_PORTS-1:0]                 join_grant,
    output logic [`HYDRA_PORTS-1:0]                 enq,
    output hydra_pkg::desc_t                        enq_desc
);

    hydra_pkg::port_idx_t win;

    // fixed priority, lowest ingress port first
    always_comb begin
        win = '0;
        for (int p = `HYDRA_PORTS - 1; p >= 0; p--) begin
            if (join_req[p]) begin
                win = hydra_pkg::port_idx_t'(p);
            end
        end
    end

    always_comb begin
        join_grant = '0;
        if (|join_req) begin
            join_grant[win] = 1'b1;
        end
    end

    // descriptor reaches the destination queue one cycle after grant
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enq <= '0;
        end else begin
            enq <= '0;
            if (|join_req) begin
                enq[join_dest[win]] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (|join_req) begin
            enq_desc <= join_desc[win];
        end
    end

endmodule

/* hw/egress_port.sv */
`include "hydra_cfg.svh"

module egress_port (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                ready,
    input  logic                                enq,
    input  hydra_pkg::desc_t                    enq_desc,
    output logic [`HYDRA_PORTS-1:0]             rd_req,
    output hydra_pkg::slot_idx_t                rd_slot,
    output hydra_pkg::offset_t                  rd_offset,
    output logic                                rd_release,
    input  logic [`HYDRA_PORTS-1:0]             rd_grant,
    input  hydra_pkg::word_t [`HYDRA_PORTS-1:0] rd_word,
    output logic                                rd_sop,
    output logic                                rd_vld,
    output logic                                rd_eop,
    output hydra_pkg::word_t                    rd_data
);

    localparam int QW = $clog2(`HYDRA_QDEPTH);

    hydra_pkg::desc_t          queue [`HYDRA_PRIORS][`HYDRA_QDEPTH];
    hydra_pkg::qptr_t          head [`HYDRA_PRIORS];
    hydra_pkg::qptr_t          tail [`HYDRA_PRIORS];
    logic [`HYDRA_PRIORS-1:0]  q_empty;
    logic [`HYDRA_PRIORS-1:0]  q_full;
    hydra_pkg::egress_state_e  state;
    hydra_pkg::desc_t          cur;
    hydra_pkg::offset_t        cnt;
    hydra_pkg::prio_t          pick;
    logic                      pop;
    logic                      last;

    always_comb begin
        for (int p = 0; p < `HYDRA_PRIORS; p++) begin
            q_empty[p] = head[p] == tail[p];
            q_full[p]  = (head[p][QW] != tail[p][QW]) && (head[p][QW-1:0] == tail[p][QW-1:0]);
        end
    end

    // strict priority, highest nonempty level wins
    always_comb begin
        pick = '0;
        for (int p = 0; p < `HYDRA_PRIORS; p++) begin
            if (!q_empty[p]) begin
                pick = hydra_pkg::prio_t'(p);
            end
        end
    end

    // ready only matters when a new packet is picked
    assign pop  = (state == hydra_pkg::e_idle) && ready && !(&q_empty);
    assign last = hydra_pkg::len_t'(cnt) == cur.len - 1'b1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int p = 0; p < `HYDRA_PRIORS; p++) begin
                head[p] <= '0;
                tail[p] <= '0;
            end
        end else begin
            if (enq) begin
                tail[enq_desc.prio] <= tail[enq_desc.prio] + 1'b1;
            end
            if (pop) begin
                head[pick] <= head[pick] + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enq) begin
            queue[enq_desc.prio][tail[enq_desc.prio][QW-1:0]] <= enq_desc;
        end
        if (pop) begin
            cur <= queue[pick][head[pick][QW-1:0]];
        end
    end

    // addresses go out in e_stream, data and flags follow a cycle later
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= hydra_pkg::e_idle;
            cnt    <= '0;
            rd_sop <= 1'b0;
            rd_vld <= 1'b0;
            rd_eop <= 1'b0;
        end else begin
            rd_vld <= state == hydra_pkg::e_stream;
            rd_sop <= state == hydra_pkg::e_stream && cnt == '0;
            rd_eop <= state == hydra_pkg::e_stream && last;
            case (state)
                hydra_pkg::e_idle: begin
                    if (pop) begin
                        state <= hydra_pkg::e_wait_grant;
                    end
                end
                hydra_pkg::e_wait_grant: begin
                    if (rd_grant[cur.bank]) begin
                        state <= hydra_pkg::e_stream;
                        cnt   <= '0;
                    end
                end
                hydra_pkg::e_stream: begin
                    cnt <= cnt + 1'b1;
                    if (last) begin
                        state <= hydra_pkg::e_idle;
                    end
                end
                default: state <= hydra_pkg::e_idle;
            endcase
        end
    end

    always_comb begin
        rd_req = '0;
        if (state != hydra_pkg::e_idle) begin
            rd_req[cur.bank] = 1'b1;
        end
    end

    assign rd_slot   = cur.slot;
    assign rd_offset = cnt;
    // bank still owned by this port while the last word leaves
    assign rd_release = rd_eop;
    assign rd_data    = rd_word[cur.bank];

    assert property (@(posedge clk) disable iff (!rst_n) enq |-> !q_full[enq_desc.prio])
        else $error("egress_port: push into full queue %0d", enq_desc.prio);

endmodule

/* hw/hydra_lite.sv */
`include "hydra_cfg.svh"

module hydra_lite (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [`HYDRA_PORTS-1:0]             wr_sop,
    input  logic [`HYDRA_PORTS-1:0]             wr_vld,
    input  logic [`HYDRA_PORTS-1:0]             wr_eop,
    input  hydra_pkg::word_t [`HYDRA_PORTS-1:0] wr_data,
    input  logic [`HYDRA_PORTS-1:0]             ready,
    output logic [`HYDRA_PORTS-1:0]             pause,
    output logic                                full,
    output logic [`HYDRA_PORTS-1:0]             rd_sop,
    output logic [`HYDRA_PORTS-1:0]             rd_vld,
    output logic [`HYDRA_PORTS-1:0]             rd_eop,
    output hydra_pkg::word_t [`HYDRA_PORTS-1:0] rd_data
);

    // ingress to bank
    logic [`HYDRA_PORTS-1:0]                 slot_free;
    hydra_pkg::slot_idx_t [`HYDRA_PORTS-1:0] alloc_slot;
    logic [`HYDRA_PORTS-1:0]                 alloc;
    logic [`HYDRA_PORTS-1:0]                 wr_en;
    hydra_pkg::slot_idx_t [`HYDRA_PORTS-1:0] wr_slot;
    hydra_pkg::offset_t [`HYDRA_PORTS-1:0]   wr_offset;
    hydra_pkg::word_t [`HYDRA_PORTS-1:0]     wr_word;

    // join path
    logic [`HYDRA_PORTS-1:0]                 join_req;
    hydra_pkg::desc_t [`HYDRA_PORTS-1:0]     join_desc;
    hydra_pkg::port_idx_t [`HYDRA_PORTS-1:0] join_dest;
    logic [`HYDRA_PORTS-1:0]                 join_grant;
    logic [`HYDRA_PORTS-1:0]                 enq;
    hydra_pkg::desc_t                        enq_desc;

    // read side, egress view is [port][bank], bank view is [bank][port]
    logic [`HYDRA_PORTS-1:0]                 egr_rd_req [`HYDRA_PORTS];
    logic [`HYDRA_PORTS-1:0]                 bank_rd_req [`HYDRA_PORTS];
    logic [`HYDRA_PORTS-1:0]                 bank_rd_grant [`HYDRA_PORTS];
    logic [`HYDRA_PORTS-1:0]                 egr_rd_grant [`HYDRA_PORTS];
    hydra_pkg::slot_idx_t [`HYDRA_PORTS-1:0] egr_rd_slot;
    hydra_pkg::offset_t [`HYDRA_PORTS-1:0]   egr_rd_offset;
    logic [`HYDRA_PORTS-1:0]                 egr_rd_release;
    hydra_pkg::word_t [`HYDRA_PORTS-1:0]     bank_rd_word;

    assign full = ~|slot_free;

    join_arbiter u_join (
        .clk        (clk),
        .rst_n      (rst_n),
        .join_req   (join_req),
        .join_desc  (join_desc),
        .join_dest  (join_dest),
        .join_grant (join_grant),
        .enq        (enq),
        .enq_desc   (enq_desc)
    );

    for (genvar g = 0; g < `HYDRA_PORTS; g++) begin : g_port
        for (genvar j = 0; j < `HYDRA_PORTS; j++) begin : g_xpose
            assign bank_rd_req[g][j]  = egr_rd_req[j][g];
            assign egr_rd_grant[g][j] = bank_rd_grant[j][g];
        end

        ingress_port #(.BANK_ID(g)) u_ingress (
            .clk (clk), .rst_n (rst_n),
            .wr_sop (wr_sop[g]), .wr_vld (wr_vld[g]), .wr_eop (wr_eop[g]),
            .wr_data (wr_data[g]), .slot_free (slot_free[g]), .alloc_slot (alloc_slot[g]),
            .pause (pause[g]), .alloc (alloc[g]), .wr_en (wr_en[g]),
            .wr_slot (wr_slot[g]), .wr_offset (wr_offset[g]), .wr_word (wr_word[g]),
            .join_req (join_req[g]), .join_desc (join_desc[g]),
            .join_dest (join_dest[g]), .join_grant (join_grant[g])
        );

        packet_bank u_bank (
            .clk (clk), .rst_n (rst_n),
            .alloc (alloc[g]), .wr_en (wr_en[g]), .wr_slot (wr_slot[g]),
            .wr_offset (wr_offset[g]), .wr_word (wr_word[g]),
            .rd_req (bank_rd_req[g]), .rd_slot (egr_rd_slot),
            .rd_offset (egr_rd_offset), .rd_release (egr_rd_release),
            .slot_free (slot_free[g]), .alloc_slot (alloc_slot[g]),
            .rd_grant (bank_rd_grant[g]), .rd_word (bank_rd_word[g])
        );

        egress_port u_egress (
            .clk (clk), .rst_n (rst_n),
            .ready (ready[g]), .enq (enq[g]), .enq_desc (enq_desc),
            .rd_req (egr_rd_req[g]), .rd_slot (egr_rd_slot[g]),
            .rd_offset (egr_rd_offset[g]), .rd_release (egr_rd_release[g]),
            .rd_grant (egr_rd_grant[g]), .rd_word (bank_rd_word),
            .rd_sop (rd_sop[g]), .rd_vld (rd_vld[g]), .rd_eop (rd_eop[g]),
            .rd_data (rd_data[g])
        );
    end

endmodule

/* tests/hydra_checker.sv */
`include "hydra_cfg.svh"

module hydra_checker (
    input logic                                     clk,
    input logic                                     rst_n,
    input logic [`HYDRA_PORTS-1:0]                  rd_sop,
    input logic [`HYDRA_PORTS-1:0]                  rd_vld,
    input logic [`HYDRA_PORTS-1:0]                  rd_eop,
    input logic [`HYDRA_PORTS-1:0][`HYDRA_WORD-1:0] rd_data,
    input logic [`HYDRA_PORTS-1:0]                  pause,
    input logic                                     full,
    input logic                                     ordered
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAXP = 64;

    int exp_src [MAXP];
    int exp_dst [MAXP];
    int exp_prio [MAXP];
    int exp_len [MAXP];
    int exp_tag [MAXP];
    bit exp_done [MAXP];
    int n_exp = 0;
    int received = 0;
    int errors = 0;

    logic [`HYDRA_WORD-1:0] cap [`HYDRA_PORTS][`HYDRA_SLOT_WORDS];
    int cap_len [`HYDRA_PORTS];
    bit in_pkt [`HYDRA_PORTS];
    int last_prio [`HYDRA_PORTS];
    logic ordered_q = 1'b0;

    task automatic add_packet(input int src, input int dst, input int prio,
                              input int len, input int tag);
        exp_src[n_exp]  = src;
        exp_dst[n_exp]  = dst;
        exp_prio[n_exp] = prio;
        exp_len[n_exp]  = len;
        exp_tag[n_exp]  = tag;
        exp_done[n_exp] = 1'b0;
        n_exp++;
    endtask

    task automatic check_flags(input logic [`HYDRA_PORTS-1:0] exp_pause, input logic exp_full);
        if (pause !== exp_pause) begin
            errors++;
            $display("error @%0t ns: pause is %b, expected %b", $time, pause, exp_pause);
        end
        if (full !== exp_full) begin
            errors++;
            $display("error @%0t ns: full is %b, expected %b", $time, full, exp_full);
        end
    endtask

    // word 0 is the header, payload word i is tag + i
    function automatic logic [`HYDRA_WORD-1:0] expected_word(input int k, input int i);
        logic [`HYDRA_WORD-1:0] w;
        if (i == 0) begin
            w = `HYDRA_WORD'((exp_tag[k] << 4) | (exp_prio[k] << 2) | exp_dst[k]);
        end else begin
            w = `HYDRA_WORD'(exp_tag[k] + i);
        end
        return w;
    endfunction

    task automatic match_packet(input int port);
        int k;
        int tag;
        k   = -1;
        tag = cap[port][0][15:4];
        for (int j = 0; j < n_exp; j++) begin
            if (k < 0 && !exp_done[j] && exp_tag[j] == tag) begin
                k = j;
            end
        end
        if (k < 0) begin
            errors++;
            $display("error @%0t ns: port %0d sent unknown tag %h", $time, port, tag);
        end else begin
            exp_done[k] = 1'b1;
            received++;
            if (exp_dst[k] != port) begin
                errors++;
                $display("error @%0t ns: tag %h left port %0d, expected port %0d",
                         $time, tag, port, exp_dst[k]);
            end
            if (cap_len[port] != exp_len[k]) begin
                errors++;
                $display("error @%0t ns: tag %h has %0d words, expected %0d",
                         $time, tag, cap_len[port], exp_len[k]);
            end else begin
                for (int i = 0; i < exp_len[k]; i++) begin
                    if (cap[port][i] !== expected_word(k, i)) begin
                        errors++;
                        $display("error @%0t ns: tag %h word %0d is %h, expected %h",
                                 $time, tag, i, cap[port][i], expected_word(k, i));
                    end
                end
            end
            // an older packet on the same flow must already be out
            for (int j = 0; j < k; j++) begin
                if (!exp_done[j] && exp_src[j] == exp_src[k] && exp_dst[j] == exp_dst[k]
                    && exp_prio[j] == exp_prio[k]) begin
                    errors++;
                    $display("error @%0t ns: tag %h overtook tag %h", $time, tag, exp_tag[j]);
                end
            end
            if (ordered) begin
                if (exp_prio[k] > last_prio[port]) begin
                    errors++;
                    $display("error @%0t ns: port %0d priority rose to %0d",
                             $time, port, exp_prio[k]);
                end
                last_prio[port] = exp_prio[k];
            end
        end
    endtask

    task automatic finish_check();
        for (int j = 0; j < n_exp; j++) begin
            if (!exp_done[j]) begin
                errors++;
                $display("packet with tag %h from port %0d to port %0d never arrived",
                         exp_tag[j], exp_src[j], exp_dst[j]);
            end
        end
    endtask

    // sampled away from the rising edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (ordered && !ordered_q) begin
                for (int p = 0; p < `HYDRA_PORTS; p++) begin
                    last_prio[p] = `HYDRA_PRIORS - 1;
                end
            end
            ordered_q = ordered;
            if (n_exp == 0 && (pause != 0 || full || rd_sop != 0 || rd_vld != 0)) begin
                errors++;
                $display("error @%0t ns: outputs active before any packet", $time);
            end
            for (int p = 0; p < `HYDRA_PORTS; p++) begin
                if ((rd_sop[p] || rd_eop[p]) && !rd_vld[p]) begin
                    errors++;
                    $display("error @%0t ns: port %0d sop or eop without vld", $time, p);
                end
                if (rd_vld[p]) begin
                    if (rd_sop[p]) begin
                        if (in_pkt[p]) begin
                            errors++;
                            $display("error @%0t ns: port %0d sop inside a packet", $time, p);
                        end
                        in_pkt[p]  = 1'b1;
                        cap_len[p] = 0;
                    end else if (!in_pkt[p]) begin
                        errors++;
                        $display("error @%0t ns: port %0d vld outside a packet", $time, p);
                    end
                    if (in_pkt[p]) begin
                        if (cap_len[p] < `HYDRA_SLOT_WORDS) begin
                            cap[p][cap_len[p]] = rd_data[p];
                        end
                        cap_len[p]++;
                        if (rd_eop[p]) begin
                            in_pkt[p] = 1'b0;
                            match_packet(p);
                        end
                    end
                end
            end
        end
    end

endmodule

/* tests/tb_hydra_lite.sv */
`include "hydra_cfg.svh"

module tb_hydra_lite;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAXC = 128;

    logic                                     clk;
    logic                                     rst_n;
    logic [`HYDRA_PORTS-1:0]                  wr_sop;
    logic [`HYDRA_PORTS-1:0]                  wr_vld;
    logic [`HYDRA_PORTS-1:0]                  wr_eop;
    logic [`HYDRA_PORTS-1:0][`HYDRA_WORD-1:0] wr_data;
    logic [`HYDRA_PORTS-1:0]                  ready;
    logic [`HYDRA_PORTS-1:0]                  pause;
    logic                                     full;
    logic [`HYDRA_PORTS-1:0]                  rd_sop;
    logic [`HYDRA_PORTS-1:0]                  rd_vld;
    logic [`HYDRA_PORTS-1:0]                  rd_eop;
    logic [`HYDRA_PORTS-1:0][`HYDRA_WORD-1:0] rd_data;
    // high while a drain runs with every descriptor already queued
    logic                                     ordered;

    byte cmd_kind [MAXC];
    int  cmd_arg [MAXC][5];
    int  n_cmd = 0;
    int  limit = 0;
    int  cycles = 0;
    bit  vec_ok;

    initial clk = 1'b0;
    always #10 clk = ~clk;

    hydra_lite dut0 (
        .clk (clk), .rst_n (rst_n),
        .wr_sop (wr_sop), .wr_vld (wr_vld), .wr_eop (wr_eop), .wr_data (wr_data),
        .ready (ready), .pause (pause), .full (full),
        .rd_sop (rd_sop), .rd_vld (rd_vld), .rd_eop (rd_eop), .rd_data (rd_data)
    );

    hydra_checker u_chk (
        .clk (clk), .rst_n (rst_n),
        .rd_sop (rd_sop), .rd_vld (rd_vld), .rd_eop (rd_eop), .rd_data (rd_data),
        .pause (pause), .full (full), .ordered (ordered)
    );

    task automatic read_vectors(output bit ok);
        int    fd;
        int    n;
        string line;
        byte   c;
        int    a [5];
        ok = 1'b0;
        fd = $fopen("tests/hydra_vectors.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 0) begin
                    c = line.getc(0);
                    a = '{0, 0, 0, 0, 0};
                    case (c)
                        "P": n = $sscanf(line, "%c %d %d %d %d %h", c, a[0], a[1], a[2],
                                         a[3], a[4]);
                        "R": n = $sscanf(line, "%c %h", c, a[0]);
                        "W": n = $sscanf(line, "%c %d", c, a[0]);
                        "E": n = $sscanf(line, "%c %h %d", c, a[0], a[1]);
                        default: c = 0;
                    endcase
                    if (c != 0) begin
                        cmd_kind[n_cmd] = c;
                        cmd_arg[n_cmd]  = a;
                        n_cmd++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic send_packet(input int src, input int dst, input int prio,
                               input int len, input int tag);
        logic [`HYDRA_WORD-1:0] w;
        while (pause[src]) begin
            step();
        end
        for (int i = 0; i < len; i++) begin
            if (i == 0) begin
                w = `HYDRA_WORD'((tag << 4) | (prio << 2) | dst);
            end else begin
                w = `HYDRA_WORD'(tag + i);
            end
            wr_sop[src]  = (i == 0);
            wr_vld[src]  = 1'b1;
            wr_eop[src]  = (i == len - 1);
            wr_data[src] = w;
            step();
        end
        wr_sop[src] = 1'b0;
        wr_vld[src] = 1'b0;
        wr_eop[src] = 1'b0;
        // pause trails the slot allocation by two edges
        step();
        step();
    endtask

    task automatic run_commands();
        for (int k = 0; k < n_cmd; k++) begin
            case (cmd_kind[k])
                "P": begin
                    ordered = 1'b0;
                    send_packet(cmd_arg[k][0], cmd_arg[k][1], cmd_arg[k][2],
                                cmd_arg[k][3], cmd_arg[k][4]);
                    // listed once written, well before it can reach an egress port
                    u_chk.add_packet(cmd_arg[k][0], cmd_arg[k][1], cmd_arg[k][2],
                                     cmd_arg[k][3], cmd_arg[k][4]);
                end
                "R": begin
                    if (ready == 0 && cmd_arg[k][0] != 0) begin
                        ordered = 1'b1;
                    end
                    ready = `HYDRA_PORTS'(cmd_arg[k][0]);
                end
                "W": repeat (cmd_arg[k][0]) step();
                "E": u_chk.check_flags(`HYDRA_PORTS'(cmd_arg[k][0]), cmd_arg[k][1] != 0);
                default: ;
            endcase
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        rst_n   = 1'b0;
        wr_sop  = '0;
        wr_vld  = '0;
        wr_eop  = '0;
        wr_data = '0;
        ready   = '0;
        ordered = 1'b0;
        read_vectors(vec_ok);
        if (!vec_ok) begin
            $display("vector file tests/hydra_vectors.txt could not be opened");
            $display("SOME TESTS FAILED");
            $finish;
        end else begin
            limit = 200;
            for (int k = 0; k < n_cmd; k++) begin
                if (cmd_kind[k] == "P") begin
                    limit += 8 * cmd_arg[k][3];
                end else if (cmd_kind[k] == "W") begin
                    limit += cmd_arg[k][0];
                end
            end
            repeat (5) @(posedge clk);
            #1;
            rst_n = 1'b1;
            run_commands();
            u_chk.finish_check();
            $display("packets expected %0d, received %0d, errors %0d",
                     u_chk.n_exp, u_chk.received, u_chk.errors);
            if (u_chk.errors == 0) begin
                $display("ALL TESTS PASSED");
            end else begin
                $display("SOME TESTS FAILED");
            end
            $finish;
        end
    end

endmodule

/* hydra_lite.f */
+incdir+include
hw/hydra_pkg.sv
hw/ingress_port.sv
hw/packet_bank.sv
hw/join_arbiter.sv
hw/egress_port.sv
hw/hydra_lite.sv
tests/hydra_checker.sv
tests/tb_hydra_lite.sv

/* tests/hydra_vectors.txt */
# P src dst prio len tag(hex), R ready mask(hex), W cycles
# E pause mask(hex) full
R f
P 0 1 0 4 001
P 0 2 1 1 002
P 1 3 2 16 003
P 2 0 3 6 004
P 3 3 0 2 005
P 3 3 0 3 006
P 1 0 1 5 007
W 60
E 0 0
R 0
P 0 2 0 3 010
P 1 2 3 2 011
P 2 2 1 4 012
P 3 2 2 2 013
P 0 1 1 2 014
P 2 1 3 3 015
P 3 1 0 2 016
W 20
R f
W 150
E 0 0
R 0
P 0 1 0 2 020
P 0 2 3 3 021
P 0 3 1 2 022
P 0 1 2 4 023
W 2
E 1 0
P 1 0 2 3 024
P 1 2 0 2 025
P 1 3 3 1 026
P 1 0 1 2 027
P 2 3 0 3 028
P 2 1 1 2 029
P 2 0 3 2 02a
P 2 2 2 3 02b
P 3 0 0 2 02c
P 3 1 3 3 02d
P 3 2 1 2 02e
P 3 3 2 4 02f
W 4
E f 1
R f
W 300
E 0 0
